// ==== build.f ====
+incdir+dv
logic/huff_pkg.sv
logic/huff_ctrl_fsm.sv
logic/huff_step_counter.sv
logic/min_pair_finder.sv
logic/tree_merge_unit.sv
logic/code_serializer.sv
logic/huff_top.sv
dv/tb_huff_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the Huffman coder testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f build.f --top-module tb_huff_top -o tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "compile failed, see build.log"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
exit 0

// ==== dv/huff_ref_model.svh ====
`ifndef HUFF_REF_MODEL_SVH
`define HUFF_REF_MODEL_SVH

// 32-bit LCG, the upper bits are the ones worth using
function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
endfunction

// weight first, tag breaks ties
function automatic bit ranks_below(input int wa, input int tag_a, input int wb, input int tag_b);
    return (wa < wb) || (wa == wb && tag_a < tag_b);
endfunction

// ============================================================
// reference Huffman coder
// ============================================================

// stream holds the sent bits right-justified, first bit sent is the highest used bit
function automatic void huffman_model(
    input  int          w [8],
    input  bit          md,
    output logic [63:0] stream,
    output int          nbits
);
    int         nw    [8];
    int         tag   [8];
    logic [7:0] mem   [8];
    bit         live  [8];
    int         code  [8];
    int         len   [8];
    int         order [2][5];
    int         lo;
    int         hi;
    int         sym;
    order = '{'{3, 2, 1, 0, 4}, '{3, 5, 2, 7, 6}};
    for (int i = 0; i < 8; i++) begin
        nw[i]   = w[i];
        tag[i]  = 8 + i;
        mem[i]  = 8'(1 << i);
        live[i] = 1'b1;
        code[i] = 0;
        len[i]  = 0;
    end
    for (int r = 0; r < 7; r++) begin
        lo = -1;
        hi = -1;
        for (int i = 0; i < 8; i++) begin
            if (live[i]) begin
                if (lo < 0 || ranks_below(nw[i], tag[i], nw[lo], tag[lo])) begin
                    hi = lo;
                    lo = i;
                end else if (hi < 0 || ranks_below(nw[i], tag[i], nw[hi], tag[hi])) begin
                    hi = i;
                end
            end
        end
        // each new bit sits above the bits already collected
        for (int s = 0; s < 8; s++) begin
            if (mem[lo][s]) begin
                code[s] = code[s] + (1 << len[s]);
                len[s]++;
            end else if (mem[hi][s]) begin
                len[s]++;
            end
        end
        nw[lo]   = nw[lo] + nw[hi];
        mem[lo]  = mem[lo] | mem[hi];
        tag[lo]  = 7 - r;
        live[hi] = 1'b0;
    end
    stream = '0;
    nbits  = 0;
    for (int p = 0; p < 5; p++) begin
        sym = order[md][p];
        for (int b = len[sym] - 1; b >= 0; b--) begin
            stream = {stream[62:0], code[sym][b]};
            nbits++;
        end
    end
endfunction

`endif

// ==== dv/tb_huff_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_huff_top;

    localparam int WEIGHT_W    = 3;
    localparam int NUM_ROWS    = 12;
    localparam int CYCLE_LIMIT = NUM_ROWS * (16 + 7 + 5 * 7 * 4);

    logic                clk;
    logic                rst_n;
    logic                in_valid;
    logic                in_ready;
    logic [WEIGHT_W-1:0] in_weight;
    logic                mode;
    logic                out_valid;
    logic                out_ready;
    logic                out_code;
    logic                out_last;

    int          cycle_count = 0;
    int          error_count = 0;
    int          failed_rows = 0;
    logic [31:0] rand_state  = 32'd99160;

    // one frame per row, hand rows carry their own expected stream
    int          row_weight [NUM_ROWS][8];
    bit          row_mode   [NUM_ROWS];
    bit          row_gap    [NUM_ROWS];
    int          row_stall  [NUM_ROWS];
    logic [63:0] row_exp    [NUM_ROWS];
    int          row_nbits  [NUM_ROWS];
    bit          row_hand   [NUM_ROWS];

    `include "huff_ref_model.svh"

    huff_top #(.WEIGHT_W(WEIGHT_W)) dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_weight (in_weight),
        .mode      (mode),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_code  (out_code),
        .out_last  (out_last)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic flag_error(input string msg);
        $display("ERROR %0t ns: %s", $time, msg);
        error_count++;
    endtask

    task automatic draw_random(input int n, output int v);
        rand_state = lcg_next(rand_state);
        v = int'(rand_state[30:16]) % n;
    endtask

    task automatic set_hand_row(input int r, input bit md, input bit gap, input int stall,
                                input logic [63:0] bits, input int nbits);
        row_mode[r]  = md;
        row_gap[r]   = gap;
        row_stall[r] = stall;
        row_exp[r]   = bits;
        row_nbits[r] = nbits;
        row_hand[r]  = 1'b1;
    endtask

    // ============================================================
    // stimulus table
    // ============================================================

    task automatic fill_table();
        int v;
        row_weight[0] = '{1, 2, 3, 4, 5, 6, 7, 7};
        row_weight[1] = '{1, 2, 3, 4, 5, 6, 7, 7};
        row_weight[2] = '{2, 2, 2, 2, 2, 2, 2, 2};
        row_weight[3] = '{0, 3, 0, 5, 1, 7, 2, 0};
        set_hand_row(0, 1'b0, 1'b0, 0, 64'b01100100011000111010, 20);
        set_hand_row(1, 1'b1, 1'b1, 0, 64'b01100000101011, 14);
        // all equal weights give 3-bit codes
        set_hand_row(2, 1'b0, 1'b0, 2, 64'b110111100101001, 15);
        set_hand_row(3, 1'b1, 1'b1, 1, 64'b01100111100011100010, 20);
        for (int r = 4; r < NUM_ROWS; r++) begin
            for (int i = 0; i < 8; i++) begin
                draw_random(1 << WEIGHT_W, v);
                row_weight[r][i] = v;
            end
            draw_random(2, v);
            row_mode[r] = v[0];
            draw_random(2, v);
            row_gap[r] = v[0];
            draw_random(3, v);
            row_stall[r] = v;
        end
    endtask

    // ============================================================
    // one frame: load, then collect the code stream
    // ============================================================

    task automatic run_row(input int r);
        int   beat;
        int   n;
        int   v;
        int   beat_cyc;
        int   errs_before;
        bit   done;
        bit   rose;
        bit   prev_stall;
        logic prev_code;
        logic prev_last;
        errs_before = error_count;
        beat        = 0;
        beat_cyc    = 0;
        while (beat < 8) begin
            @(negedge clk);
            v = 1;
            if (row_gap[r]) begin
                draw_random(2, v);
            end
            in_valid = 1'b0;
            if (v != 0 && !in_ready) begin
                flag_error("in_ready low while loading weights");
            end else if (v != 0) begin
                in_valid  = 1'b1;
                in_weight = WEIGHT_W'(row_weight[r][beat]);
                // only the first beat's mode counts
                mode      = (beat == 0) ? row_mode[r] : ~row_mode[r];
                beat_cyc  = cycle_count;
                beat++;
            end
        end
        n          = 0;
        done       = 1'b0;
        rose       = 1'b0;
        prev_stall = 1'b0;
        prev_code  = 1'b0;
        prev_last  = 1'b0;
        while (!done) begin
            @(negedge clk);
            in_valid = 1'b0;
            if (in_ready) begin
                flag_error("in_ready high before the last code bit");
            end
            if (prev_stall && (!out_valid || out_code !== prev_code || out_last !== prev_last)) begin
                flag_error("output changed while out_ready was low");
            end
            if (out_valid && !rose) begin
                rose = 1'b1;
                if (cycle_count - beat_cyc != 8) begin
                    flag_error($sformatf("out_valid rose %0d cycles after the last weight",
                                         cycle_count - beat_cyc));
                end
            end
            draw_random(4, v);
            out_ready = (v >= row_stall[r]);
            if (out_valid && out_ready) begin
                if (n >= row_nbits[r]) begin
                    flag_error("more code bits than expected");
                    done = 1'b1;
                end else begin
                    if (out_code !== row_exp[r][row_nbits[r] - 1 - n]) begin
                        flag_error($sformatf("bit %0d is %b, expected %b", n, out_code,
                                             row_exp[r][row_nbits[r] - 1 - n]));
                    end
                    if (out_last !== (n == row_nbits[r] - 1)) begin
                        flag_error($sformatf("out_last is %b at bit %0d", out_last, n));
                    end
                    n++;
                    done = out_last;
                end
            end
            prev_stall = out_valid && !out_ready;
            prev_code  = out_code;
            prev_last  = out_last;
        end
        @(negedge clk);
        out_ready = 1'b0;
        if (!in_ready || out_valid) begin
            flag_error("coder not back in load after the last bit");
        end
        if (n != row_nbits[r]) begin
            flag_error($sformatf("got %0d bits, expected %0d", n, row_nbits[r]));
        end
        if (error_count != errs_before) begin
            failed_rows++;
        end
        $display("row %0d: mode %0d, %0d of %0d bits, %s", r, row_mode[r], n, row_nbits[r],
                 (error_count == errs_before) ? "pass" : "FAIL");
    endtask

    initial begin
        logic [63:0] model_bits;
        int          model_nbits;
        int          w [8];
        clk       = 1'b0;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_weight = '0;
        mode      = 1'b0;
        out_ready = 1'b0;
        fill_table();
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        if (!in_ready || out_valid || out_last) begin
            flag_error("outputs not idle after reset");
        end
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int i = 0; i < 8; i++) begin
                w[i] = row_weight[r][i];
            end
            huffman_model(w, row_mode[r], model_bits, model_nbits);
            if (!row_hand[r]) begin
                row_exp[r]   = model_bits;
                row_nbits[r] = model_nbits;
            end else if (model_bits != row_exp[r] || model_nbits != row_nbits[r]) begin
                flag_error($sformatf("model disagrees with hand-worked stream in row %0d", r));
            end
            run_row(r);
        end
        $display("rows %0d, rows failed %0d, errors %0d", NUM_ROWS, failed_rows, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/huff_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module huff_top #(
    parameter int WEIGHT_W = 3
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    output logic                in_ready,
    input  logic [WEIGHT_W-1:0] in_weight,
    input  logic                mode,
    output logic                out_valid,
    input  logic                out_ready,
    output logic                out_code,
    output logic                out_last
);

    import huff_pkg::*;

    localparam int NODE_W = WEIGHT_W + SYM_W;

    phase_t               phase;
    logic                 mode_q;
    logic [SYM_W-1:0]     step;
    logic [SYM_W-1:0]     sym_idx;
    logic                 step_last;
    logic                 sym_done;
    logic [SYM_W-1:0]     lo_slot;
    logic [SYM_W-1:0]     hi_slot;
    logic [NODE_W-1:0]    node_weight [SYM_COUNT];
    logic [TAG_W-1:0]     node_tag    [SYM_COUNT];
    logic [SYM_COUNT-1:0] node_live;
    logic [CODE_W-1:0]    sym_code    [SYM_COUNT];
    logic [LEN_W-1:0]     sym_len     [SYM_COUNT];

    // ============================================================
    // control
    // ============================================================

    huff_ctrl_fsm ctrl_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .step_last (step_last),
        .sym_done  (sym_done),
        .mode      (mode),
        .in_ready  (in_ready),
        .phase     (phase),
        .mode_q    (mode_q)
    );

    huff_step_counter counter_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .phase     (phase),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .sym_done  (sym_done),
        .step      (step),
        .sym_idx   (sym_idx),
        .step_last (step_last)
    );

    // ============================================================
    // tree build and output
    // ============================================================

    min_pair_finder #(.WEIGHT_W(WEIGHT_W)) finder_i (
        .node_weight (node_weight),
        .node_tag    (node_tag),
        .node_live   (node_live),
        .lo_slot     (lo_slot),
        .hi_slot     (hi_slot)
    );

    tree_merge_unit #(.WEIGHT_W(WEIGHT_W)) merge_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .phase       (phase),
        .step        (step),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_weight   (in_weight),
        .lo_slot     (lo_slot),
        .hi_slot     (hi_slot),
        .node_weight (node_weight),
        .node_tag    (node_tag),
        .node_live   (node_live),
        .sym_code    (sym_code),
        .sym_len     (sym_len)
    );

    code_serializer serializer_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .phase     (phase),
        .mode_q    (mode_q),
        .sym_idx   (sym_idx),
        .step_last (step_last),
        .sym_code  (sym_code),
        .sym_len   (sym_len),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .out_code  (out_code),
        .out_last  (out_last),
        .sym_done  (sym_done)
    );

endmodule

`default_nettype wire

// ==== logic/code_serializer.sv ====
`timescale 1ns/1ns
`default_nettype none

module code_serializer (
    input  logic                        clk,
    input  logic                        rst_n,
    input  huff_pkg::phase_t            phase,
    input  logic                        mode_q,
    input  logic [huff_pkg::SYM_W-1:0]  sym_idx,
    input  logic                        step_last,
    input  logic [huff_pkg::CODE_W-1:0] sym_code [huff_pkg::SYM_COUNT],
    input  logic [huff_pkg::LEN_W-1:0]  sym_len  [huff_pkg::SYM_COUNT],
    input  logic                        out_ready,
    output logic                        out_valid,
    output logic                        out_code,
    output logic                        out_last,
    output logic                        sym_done
);

    import huff_pkg::*;

    logic [SYM_W-1:0]  cur_sym;
    logic [CODE_W-1:0] cur_code;
    logic [CODE_W-1:0] code_shift;
    logic [LEN_W-1:0]  rem_q;
    logic [LEN_W-1:0]  remaining;
    logic [LEN_W-1:0]  bit_idx;
    logic              load_q;
    logic              xfer;

    // ============================================================
    // symbol select and current bit
    // ============================================================

    assign cur_sym  = EMIT_ORDER[mode_q][sym_idx];
    assign cur_code = sym_code[cur_sym];

    // a fresh symbol takes its full length straight from the code table,
    // so the first bit of the next code follows sym_done with no gap
    assign remaining = load_q ? sym_len[cur_sym] : rem_q;
    assign bit_idx   = remaining - 1'b1;

    // root bit is the highest filled index
    assign code_shift = cur_code >> bit_idx;

    assign out_valid = (phase == PH_EMIT);
    assign out_code  = out_valid & code_shift[0];
    assign out_last  = out_valid & (remaining == LEN_W'(1)) & step_last;

    assign xfer     = out_valid & out_ready;
    assign sym_done = xfer & (remaining == LEN_W'(1));

    // ============================================================
    // bit countdown
    // ============================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_q <= 1'b1;
            rem_q  <= '0;
        end else begin
            if (phase != PH_EMIT) begin
                // arm for the first symbol of the next emit phase
                load_q <= 1'b1;
                rem_q  <= '0;
            end else if (xfer) begin
                load_q <= (remaining == LEN_W'(1));
                rem_q  <= remaining - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/tree_merge_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module tree_merge_unit #(
    parameter  int WEIGHT_W = 3,
    localparam int NODE_W   = WEIGHT_W + huff_pkg::SYM_W
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  huff_pkg::phase_t               phase,
    input  logic [huff_pkg::SYM_W-1:0]     step,
    input  logic                           in_valid,
    input  logic                           in_ready,
    input  logic [WEIGHT_W-1:0]            in_weight,
    input  logic [huff_pkg::SYM_W-1:0]     lo_slot,
    input  logic [huff_pkg::SYM_W-1:0]     hi_slot,
    output logic [NODE_W-1:0]              node_weight [huff_pkg::SYM_COUNT],
    output logic [huff_pkg::TAG_W-1:0]     node_tag    [huff_pkg::SYM_COUNT],
    output logic [huff_pkg::SYM_COUNT-1:0] node_live,
    output logic [huff_pkg::CODE_W-1:0]    sym_code    [huff_pkg::SYM_COUNT],
    output logic [huff_pkg::LEN_W-1:0]     sym_len     [huff_pkg::SYM_COUNT]
);

    import huff_pkg::*;

    // which leaf symbols sit under each node
    logic [SYM_COUNT-1:0] member [SYM_COUNT];

    logic load_beat;
    logic first_beat;
    logic merge_en;

    assign load_beat  = in_valid & in_ready & (phase == PH_LOAD);
    assign first_beat = load_beat & (step == '0);
    assign merge_en   = (phase == PH_MERGE);

    // ============================================================
    // live flags
    // ============================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            node_live <= '0;
        end else begin
            if (first_beat) begin
                node_live <= '1;
            end else if (merge_en) begin
                // the merged node lives on in lo_slot
                node_live[hi_slot] <= 1'b0;
            end
        end
    end

    // ============================================================
    // node contents and per-symbol codes
    // ============================================================

    always_ff @(posedge clk) begin
        if (first_beat) begin
            for (int i = 0; i < SYM_COUNT; i++) begin
                node_tag[i] <= TAG_W'(SYM_COUNT + i);
                member[i]   <= SYM_COUNT'(1) << i;
                sym_code[i] <= '0;
                sym_len[i]  <= '0;
            end
        end

        if (load_beat) begin
            node_weight[step] <= NODE_W'(in_weight);
        end

        if (merge_en) begin
            // one level up, the new bit lands on the root side
            for (int s = 0; s < SYM_COUNT; s++) begin
                if (member[lo_slot][s]) begin
                    sym_code[s][sym_len[s]] <= 1'b1;
                    sym_len[s]              <= sym_len[s] + 1'b1;
                end else if (member[hi_slot][s]) begin
                    sym_code[s][sym_len[s]] <= 1'b0;
                    sym_len[s]              <= sym_len[s] + 1'b1;
                end
            end

            node_weight[lo_slot] <= node_weight[lo_slot] + node_weight[hi_slot];
            member[lo_slot]      <= member[lo_slot] | member[hi_slot];
            // round r gives tag 7-r, below any leaf of the same weight
            node_tag[lo_slot]    <= TAG_W'(SYM_COUNT - 1) - TAG_W'(step);
        end
    end

endmodule

`default_nettype wire

// ==== logic/min_pair_finder.sv ====
`timescale 1ns/1ns
`default_nettype none

module min_pair_finder #(
    parameter  int WEIGHT_W = 3,
    localparam int NODE_W   = WEIGHT_W + huff_pkg::SYM_W
) (
    input  logic [NODE_W-1:0]              node_weight [huff_pkg::SYM_COUNT],
    input  logic [huff_pkg::TAG_W-1:0]     node_tag    [huff_pkg::SYM_COUNT],
    input  logic [huff_pkg::SYM_COUNT-1:0] node_live,
    output logic [huff_pkg::SYM_W-1:0]     lo_slot,
    output logic [huff_pkg::SYM_W-1:0]     hi_slot
);

    import huff_pkg::*;

    // dead slots sort last, then weight, then tag
    localparam int KEY_W = 1 + NODE_W + TAG_W;

    logic [KEY_W-1:0] key [SYM_COUNT];
    logic [SYM_W-1:0] l1_lo [4];
    logic [SYM_W-1:0] l1_hi [4];
    logic [SYM_W-1:0] l2_lo [2];
    logic [SYM_W-1:0] l2_hi [2];

    // combine two sorted pairs into the best two of all four
    function automatic logic [2*SYM_W-1:0] merge_pair(
        input logic [SYM_W-1:0] a_lo,
        input logic [SYM_W-1:0] a_hi,
        input logic [SYM_W-1:0] b_lo,
        input logic [SYM_W-1:0] b_hi,
        input logic [KEY_W-1:0] k [SYM_COUNT]
    );
        logic [SYM_W-1:0] lo;
        logic [SYM_W-1:0] hi;
        if (k[a_lo] < k[b_lo]) begin
            lo = a_lo;
            hi = (k[a_hi] < k[b_lo]) ? a_hi : b_lo;
        end else begin
            lo = b_lo;
            hi = (k[a_lo] < k[b_hi]) ? a_lo : b_hi;
        end
        return {lo, hi};
    endfunction

    always_comb begin
        for (int i = 0; i < SYM_COUNT; i++) begin
            key[i] = {~node_live[i], node_weight[i], node_tag[i]};
        end
        // leaf level, tags are unique so no equal keys
        for (int i = 0; i < 4; i++) begin
            if (key[2*i] < key[2*i+1]) begin
                l1_lo[i] = SYM_W'(2*i);
                l1_hi[i] = SYM_W'(2*i+1);
            end else begin
                l1_lo[i] = SYM_W'(2*i+1);
                l1_hi[i] = SYM_W'(2*i);
            end
        end
        {l2_lo[0], l2_hi[0]} = merge_pair(l1_lo[0], l1_hi[0], l1_lo[1], l1_hi[1], key);
        {l2_lo[1], l2_hi[1]} = merge_pair(l1_lo[2], l1_hi[2], l1_lo[3], l1_hi[3], key);
        {lo_slot, hi_slot}   = merge_pair(l2_lo[0], l2_hi[0], l2_lo[1], l2_hi[1], key);
    end

endmodule

`default_nettype wire

// ==== logic/huff_step_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

module huff_step_counter (
    input  logic                       clk,
    input  logic                       rst_n,
    input  huff_pkg::phase_t           phase,
    input  logic                       in_valid,
    input  logic                       in_ready,
    input  logic                       sym_done,
    output logic [huff_pkg::SYM_W-1:0] step,
    output logic [huff_pkg::SYM_W-1:0] sym_idx,
    output logic                       step_last
);

    import huff_pkg::*;

    logic load_beat;

    assign load_beat = in_valid & in_ready;

    // end of phase limit depends on what is being counted
    always_comb begin
        case (phase)
            PH_LOAD:  step_last = (step == SYM_W'(SYM_COUNT - 1));
            PH_MERGE: step_last = (step == SYM_W'(SYM_COUNT - 2));
            PH_EMIT:  step_last = (sym_idx == SYM_W'(EMIT_COUNT - 1));
            default:  step_last = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step    <= '0;
            sym_idx <= '0;
        end else begin
            // loads advance on accepted beats, rounds on every clock
            if ((phase == PH_LOAD && load_beat) || phase == PH_MERGE) begin
                step <= step_last ? '0 : step + 1'b1;
            end
            if (phase == PH_EMIT && sym_done) begin
                sym_idx <= step_last ? '0 : sym_idx + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/huff_ctrl_fsm.sv ====
`timescale 1ns/1ns
`default_nettype none

module huff_ctrl_fsm (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  logic             step_last,
    input  logic             sym_done,
    input  logic             mode,
    output logic             in_ready,
    output huff_pkg::phase_t phase,
    output logic             mode_q
);

    import huff_pkg::*;

    phase_t phase_next;
    logic   load_beat;
    logic   first_beat;

    // weights are only taken while loading
    assign in_ready  = (phase == PH_LOAD);
    assign load_beat = in_valid & in_ready;

    // ============================================================
    // phase sequencing
    // ============================================================

    always_comb begin
        phase_next = phase;
        case (phase)
            PH_LOAD: begin
                if (load_beat && step_last) begin
                    phase_next = PH_MERGE;
                end
            end
            PH_MERGE: begin
                // seventh round done
                if (step_last) begin
                    phase_next = PH_EMIT;
                end
            end
            PH_EMIT: begin
                if (step_last && sym_done) begin
                    phase_next = PH_LOAD;
                end
            end
            default: begin
                phase_next = PH_LOAD;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= PH_LOAD;
        end else begin
            phase <= phase_next;
        end
    end

    // mode is captured with weight 0 and held for the whole frame
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            first_beat <= 1'b1;
            mode_q     <= 1'b0;
        end else begin
            if (load_beat) begin
                first_beat <= 1'b0;
                if (first_beat) begin
                    mode_q <= mode;
                end
            end else if (phase == PH_EMIT && step_last && sym_done) begin
                first_beat <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/huff_pkg.sv ====
`default_nettype none

package huff_pkg;

    // ============================================================
    // alphabet and code sizes
    // ============================================================

    // eight leaves, so seven merges and at most seven code bits
    localparam int SYM_COUNT = 8;
    localparam int SYM_W     = 3;

    // leaves carry tags 8..15, merged nodes 7 down to 1
    localparam int TAG_W     = 4;

    localparam int CODE_W    = SYM_COUNT - 1;
    localparam int LEN_W     = 3;

    // symbols streamed per frame
    localparam int EMIT_COUNT = 5;

    // ============================================================
    // controller phases
    // ============================================================

    typedef enum logic [1:0] {
        PH_LOAD  = 2'd0,
        PH_MERGE = 2'd1,
        PH_EMIT  = 2'd2
    } phase_t;

    // ============================================================
    // output order, row picked by the latched mode
    // ============================================================

    localparam logic [SYM_W-1:0] EMIT_ORDER [2][EMIT_COUNT] = '{
        // mode 0
        '{3'd3, 3'd2, 3'd1, 3'd0, 3'd4},
        // mode 1
        '{3'd3, 3'd5, 3'd2, 3'd7, 3'd6}
    };

endpackage

`default_nettype wire
